// File: src/agu_pkg.sv
/*
 * Shared widths, TLB entry and op payload types for the address stage.
 * Every module refers to these through agu_pkg:: scoped names.
 */

package agu_pkg;

  localparam int unsigned vaddr_w = 44;     // virtual and physical byte address
  localparam int unsigned page_bits = 13;   // 8 KiB pages
  localparam int unsigned row_bits = 7;     // 128-byte rows
  localparam int unsigned paddr_row_w = 36; // address bits 43:8
  localparam int unsigned ppn_w = 31;
  localparam int unsigned vpn_w = vaddr_w - page_bits;
  localparam int unsigned bank_count = 32;  // 4-byte banks
  localparam int unsigned bank_idx_w = 5;
  localparam int unsigned size_code_w = 5;
  localparam int unsigned reg_no_w = 9;
  localparam int unsigned proc_w = 24;
  localparam int unsigned fault_w = 4;

  // CSR number of the process id
  localparam logic [14:0] csr_proc_no = 15'h0c04;

  // next-page fault bits sit fault_next_ofs above the current ones
  localparam int unsigned fault_np_bit = 0;
  localparam int unsigned fault_sys_bit = 1;
  localparam int unsigned fault_next_ofs = 2;

  typedef struct packed {
    logic [ppn_w-1:0] ppn;
    logic             sys;     // supervisor only
    logic             present;
  } tlb_entry_t;

  typedef enum logic [2:0] {
    sz_b1,
    sz_b2,
    sz_b4,
    sz_b8,
    sz_b10,
    sz_b16,
    sz_b20
  } size_class_e;

  // stage 1 payload as accepted
  typedef struct packed {
    logic [vaddr_w-1:0]     vaddr;
    logic [size_code_w-1:0] size_code;
    logic [bank_idx_w-1:0]  bank0;
    logic                   store;
    logic                   split;
    logic [reg_no_w-1:0]    reg_no;
    logic                   kernel;
  } op_t;

  // stage 2 payload toward the cache
  typedef struct packed {
    logic [paddr_row_w-1:0] addr_even;
    logic [paddr_row_w-1:0] addr_odd;
    logic [bank_count-1:0]  banks;
    logic [bank_idx_w-1:0]  bank0;
    logic [size_code_w-1:0] size_code;
    logic                   store;
    logic [reg_no_w-1:0]    reg_no;
    logic [fault_w-1:0]     fault_code;
  } mem_op_t;

endpackage

// File: src/stage_reg.sv
/*
 * Payload register for one pipeline stage. Loads on load, holds
 * otherwise; the matching valid bit is kept by the control block.
 */

`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (load)
      q <= d;
  end

endmodule

// File: src/agu_ctrl.sv
/*
 * Pipeline control for the two address stages. Holds both valid bits
 * and derives the load enables, op_ready and the TLB miss flag.
 */

`timescale 1ns/1ns

module agu_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic except,
  input  logic mem_stall,
  output logic s1_valid,
  output logic s2_valid,
  input  logic op_valid,
  input  logic tlb_hit,
  input  logic need_next,
  output logic op_ready,
  output logic s1_load,
  output logic s2_load,
  output logic tlb_miss
);

  logic ready_q;  // low for the first cycle out of reset
  logic s2_hold;
  logic s1_adv;

  assign s2_hold = s2_valid & mem_stall;
  assign tlb_miss = s1_valid & ~tlb_hit;

  // stage 1 moves on once translated and stage 2 is not stuck
  assign s1_adv = s1_valid & tlb_hit & ~s2_hold;
  assign s2_load = s1_adv;

  // a page-crossing split op issues alone and the next op waits a cycle
  assign op_ready = ready_q & ~except & ~s2_hold &
                    (~s1_valid | (s1_adv & ~need_next));
  assign s1_load = op_valid & op_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (except) begin
        s1_valid <= 1'b0;  // flush everything in flight
        s2_valid <= 1'b0;
      end else begin
        if (s1_load)
          s1_valid <= 1'b1;
        else if (s1_adv)
          s1_valid <= 1'b0;
        if (s1_adv)
          s2_valid <= 1'b1;
        else if (!s2_hold)
          s2_valid <= 1'b0;  // consumer took it
      end
    end
  end

endmodule

// File: src/bank_mask_gen.sv
/*
 * Bank mask for one access. The size code gives a size class, which with
 * the low address bits sets how many 4-byte banks are touched from bank0.
 */

`timescale 1ns/1ns

module bank_mask_gen (
  input  logic [agu_pkg::size_code_w-1:0] size_code,
  input  logic [1:0]                      addr_low,
  input  logic [agu_pkg::bank_idx_w-1:0]  bank0,
  output logic [agu_pkg::bank_count-1:0]  banks
);

  agu_pkg::size_class_e sz_class;
  logic [2:0]           n_banks;
  logic                 step;
  logic                 step2;

  assign step = |addr_low;   // not bank aligned
  assign step2 = &addr_low;  // last byte of a bank

  always_comb begin
    case (size_code)
      5'd16: sz_class = agu_pkg::sz_b1;
      5'd17: sz_class = agu_pkg::sz_b2;
      5'd18: sz_class = agu_pkg::sz_b4;
      5'd19: sz_class = agu_pkg::sz_b8;
      5'd3: sz_class = agu_pkg::sz_b10;  // long double
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: sz_class = agu_pkg::sz_b16;
      5'd4, 5'd5, 5'd6: sz_class = agu_pkg::sz_b4;
      5'd8, 5'd9, 5'd10: sz_class = agu_pkg::sz_b8;
      5'd15: sz_class = agu_pkg::sz_b20;  // fill/spill
      default: sz_class = agu_pkg::sz_b8;
    endcase
  end

  always_comb begin
    case (sz_class)
      agu_pkg::sz_b1: n_banks = 3'd1;
      agu_pkg::sz_b2: n_banks = step2 ? 3'd2 : 3'd1;
      agu_pkg::sz_b4: n_banks = step ? 3'd2 : 3'd1;
      agu_pkg::sz_b8: n_banks = step ? 3'd3 : 3'd2;
      agu_pkg::sz_b10: n_banks = step2 ? 3'd4 : 3'd3;
      agu_pkg::sz_b16: n_banks = step ? 3'd5 : 3'd4;
      default: n_banks = 3'd5;
    endcase
  end

  // distance from bank0 wraps modulo 32
  for (genvar i = 0; i < agu_pkg::bank_count; i++) begin : g_bank
    assign banks[i] = 5'(5'(i) - bank0) < n_banks;
  end

endmodule

// File: src/paddr_compose.sv
/*
 * Builds the even-row and odd-row physical addresses of an access from the
 * current and next page entries. An access touches its own row and the
 * following one; the following row may sit in the next page.
 */

`timescale 1ns/1ns

module paddr_compose (
  input  logic [agu_pkg::vaddr_w-1:0]     vaddr,
  input  agu_pkg::tlb_entry_t             cur,
  input  agu_pkg::tlb_entry_t             next,
  output logic [agu_pkg::paddr_row_w-1:0] addr_even,
  output logic [agu_pkg::paddr_row_w-1:0] addr_odd,
  output logic                            page_carry
);

  logic [agu_pkg::row_bits-1:0] cur_row;
  logic [agu_pkg::row_bits-1:0] next_row;
  logic [agu_pkg::row_bits-1:0] even_row;
  logic [agu_pkg::row_bits-1:0] odd_row;
  logic [agu_pkg::ppn_w-1:0]    ppn_even;
  logic [agu_pkg::ppn_w-1:0]    ppn_odd;
  logic                         odd_start;

  assign cur_row = vaddr[agu_pkg::page_bits:agu_pkg::row_bits];  // bits 13:7
  assign next_row = cur_row + 1'b1;

  // the row index inside the page ends at bit 12, so a carry into bit 13
  // means the next row is in the next page
  assign page_carry = next_row[agu_pkg::row_bits-1] ^ cur_row[agu_pkg::row_bits-1];

  assign odd_start = vaddr[agu_pkg::row_bits];
  assign even_row = odd_start ? next_row : cur_row;
  assign odd_row = odd_start ? cur_row : next_row;

  // only the side holding the next row can cross
  assign ppn_even = (odd_start & page_carry) ? next.ppn : cur.ppn;
  assign ppn_odd = (~odd_start & page_carry) ? next.ppn : cur.ppn;

  assign addr_even = {ppn_even, even_row[agu_pkg::row_bits-2:1]};
  assign addr_odd = {ppn_odd, odd_row[agu_pkg::row_bits-2:1]};

endmodule

// File: src/fault_check.sv
/*
 * Page permission checks for the current page and, for a split access
 * that crosses, the next page. Produces the 4-bit fault code.
 */

`timescale 1ns/1ns

module fault_check (
  input  logic                        kernel,
  input  logic                        split,
  input  logic                        page_carry,
  input  logic                        tlb_hit,
  input  agu_pkg::tlb_entry_t         cur,
  input  agu_pkg::tlb_entry_t         next,
  output logic [agu_pkg::fault_w-1:0] fault_code
);

  logic use_next;

  assign use_next = split & page_carry;

  always_comb begin
    fault_code = '0;
    if (tlb_hit) begin
      fault_code[agu_pkg::fault_np_bit] = ~cur.present;
      fault_code[agu_pkg::fault_sys_bit] = cur.sys & ~kernel;  // user on sys page
      fault_code[agu_pkg::fault_np_bit + agu_pkg::fault_next_ofs] =
        use_next & ~next.present;
      fault_code[agu_pkg::fault_sys_bit + agu_pkg::fault_next_ofs] =
        use_next & next.sys & ~kernel;
    end
  end

endmodule

// File: src/agu_csr.sv
/*
 * Process-id CSR. A one-cycle write strobe to csr_proc_no loads the id
 * from the top bits of the write data; it tags every TLB lookup.
 */

`timescale 1ns/1ns

module agu_csr (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       csr_en,
  input  logic [14:0]                csr_no,
  input  logic [63:0]                csr_data,
  output logic [agu_pkg::proc_w-1:0] proc_id
);

  always_ff @(posedge clk) begin
    if (rst)
      proc_id <= '0;
    else if (csr_en && csr_no == agu_pkg::csr_proc_no)
      proc_id <= csr_data[63 -: agu_pkg::proc_w];  // id in bits 63:40
  end

endmodule

// File: src/agu_top.sv
/*
 * Address stage of the load/store unit. Ops enter on a ready/valid port,
 * are translated in stage 1 against an external TLB and leave stage 2
 * with bank mask, even/odd row addresses and fault code.
 */

`timescale 1ns/1ns

module agu_top (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           except,
  input  logic                                           op_valid,
  output logic                                           op_ready,
  input  logic [agu_pkg::vaddr_w-1:0]                    op_vaddr,
  input  logic [agu_pkg::size_code_w-1:0]                op_size_code,
  input  logic [agu_pkg::bank_idx_w-1:0]                 op_bank0,
  input  logic                                           op_store,
  input  logic                                           op_split,
  input  logic [agu_pkg::reg_no_w-1:0]                   op_reg_no,
  input  logic                                           op_kernel,
  output logic [agu_pkg::proc_w+agu_pkg::vpn_w-1:0]      tlb_vpn,
  output logic [agu_pkg::proc_w+agu_pkg::vpn_w-1:0]      tlb_vpn_next,
  input  logic                                           tlb_hit,
  input  agu_pkg::tlb_entry_t                            tlb_data,
  input  agu_pkg::tlb_entry_t                            tlb_data_next,
  input  logic                                           csr_en,
  input  logic [14:0]                                    csr_no,
  input  logic [63:0]                                    csr_data,
  output logic                                           mem_valid,
  input  logic                                           mem_stall,
  output logic [agu_pkg::paddr_row_w-1:0]                mem_addr_even,
  output logic [agu_pkg::paddr_row_w-1:0]                mem_addr_odd,
  output logic [agu_pkg::bank_count-1:0]                 mem_banks,
  output logic [agu_pkg::bank_idx_w-1:0]                 mem_bank0,
  output logic [agu_pkg::size_code_w-1:0]                mem_size_code,
  output logic                                           mem_store,
  output logic [agu_pkg::reg_no_w-1:0]                   mem_reg_no,
  output logic [agu_pkg::fault_w-1:0]                    mem_fault_code,
  output logic                                           page_fault,
  output logic                                           tlb_miss
);

  agu_pkg::op_t                         s1_d, s1_q;
  agu_pkg::mem_op_t                     s2_d, s2_q;
  logic                                 s1_valid, s2_valid;
  logic                                 s1_load, s2_load;
  logic                                 page_carry, need_next;
  logic [agu_pkg::proc_w-1:0]           proc_id;
  logic [agu_pkg::vpn_w-1:0]            vpn;
  logic [agu_pkg::bank_count-1:0]       banks;
  logic [agu_pkg::paddr_row_w-1:0]      addr_even, addr_odd;
  logic [agu_pkg::fault_w-1:0]          fault_code;

  assign s1_d = '{vaddr: op_vaddr, size_code: op_size_code, bank0: op_bank0,
                  store: op_store, split: op_split, reg_no: op_reg_no,
                  kernel: op_kernel};

  // both pages are looked up under the current process id
  assign vpn = s1_q.vaddr[agu_pkg::vaddr_w-1:agu_pkg::page_bits];
  assign tlb_vpn = {proc_id, vpn};
  assign tlb_vpn_next = {proc_id, vpn + 1'b1};
  assign need_next = s1_q.split & page_carry;

  assign s2_d = '{addr_even: addr_even, addr_odd: addr_odd, banks: banks,
                  bank0: s1_q.bank0, size_code: s1_q.size_code,
                  store: s1_q.store, reg_no: s1_q.reg_no, fault_code: fault_code};

  agu_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .mem_stall (mem_stall),
    .s1_valid  (s1_valid),
    .s2_valid  (s2_valid),
    .op_valid  (op_valid),
    .tlb_hit   (tlb_hit),
    .need_next (need_next),
    .op_ready  (op_ready),
    .s1_load   (s1_load),
    .s2_load   (s2_load),
    .tlb_miss  (tlb_miss)
  );

  stage_reg #(.payload_t(agu_pkg::op_t)) u_s1 (
    .clk  (clk),
    .load (s1_load),
    .d    (s1_d),
    .q    (s1_q)
  );

  bank_mask_gen u_banks (
    .size_code (s1_q.size_code),
    .addr_low  (s1_q.vaddr[1:0]),
    .bank0     (s1_q.bank0),
    .banks     (banks)
  );

  paddr_compose u_paddr (
    .vaddr      (s1_q.vaddr),
    .cur        (tlb_data),
    .next       (tlb_data_next),
    .addr_even  (addr_even),
    .addr_odd   (addr_odd),
    .page_carry (page_carry)
  );

  fault_check u_fault (
    .kernel     (s1_q.kernel),
    .split      (s1_q.split),
    .page_carry (page_carry),
    .tlb_hit    (tlb_hit),
    .cur        (tlb_data),
    .next       (tlb_data_next),
    .fault_code (fault_code)
  );

  stage_reg #(.payload_t(agu_pkg::mem_op_t)) u_s2 (
    .clk  (clk),
    .load (s2_load),
    .d    (s2_d),
    .q    (s2_q)
  );

  agu_csr u_csr (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_no   (csr_no),
    .csr_data (csr_data),
    .proc_id  (proc_id)
  );

  assign mem_valid = s2_valid;
  assign mem_addr_even = s2_q.addr_even;
  assign mem_addr_odd = s2_q.addr_odd;
  assign mem_banks = s2_q.banks;
  assign mem_bank0 = s2_q.bank0;
  assign mem_size_code = s2_q.size_code;
  assign mem_store = s2_q.store;
  assign mem_reg_no = s2_q.reg_no;
  assign mem_fault_code = s2_q.fault_code;
  assign page_fault = s2_valid & (|s2_q.fault_code);

endmodule

// File: testbench/agu_asserts.sv
/*
 * Concurrent checks on the pipeline valid bits and the miss flag,
 * bound into every agu_ctrl instance.
 */

`timescale 1ns/1ns

module agu_asserts (
  input logic clk,
  input logic rst,
  input logic except,
  input logic mem_stall,
  input logic s1_valid,
  input logic s2_valid,
  input logic tlb_miss
);

  int unsigned fail_count = 0;

  // a missing op stays in stage 1 until the lookup hits
  miss_holds_op: assert property (@(posedge clk) disable iff (rst)
    (tlb_miss && !except) |=> s1_valid)
    else begin
      $error("stage 1 op dropped during a TLB miss");
      fail_count++;
    end

  // consumer stall keeps the stage 2 op in place
  s2_holds: assert property (@(posedge clk) disable iff (rst)
    (s2_valid && mem_stall && !except) |=> s2_valid)
    else begin
      $error("stage 2 op dropped while mem_stall was high");
      fail_count++;
    end

  flush_clears: assert property (@(posedge clk) disable iff (rst)
    except |=> (!s1_valid && !s2_valid))
    else begin
      $error("an op stayed valid after except");
      fail_count++;
    end

endmodule

bind agu_ctrl agu_asserts u_asserts (
  .clk       (clk),
  .rst       (rst),
  .except    (except),
  .mem_stall (mem_stall),
  .s1_valid  (s1_valid),
  .s2_valid  (s2_valid),
  .tlb_miss  (tlb_miss)
);

// File: testbench/tb_agu.sv
/*
 * Testbench for the address stage. The TLB is a small table keyed by
 * process id and vpn; directed tests cover masks, addresses, faults,
 * misses, back-pressure, flush and the process-id CSR.
 */

`timescale 1ns/1ns

module tb_agu;

  localparam int slots = 16;
  localparam int wait_limit = 50;

  logic clk, rst, except, op_valid, op_ready, op_store, op_split, op_kernel;
  logic [43:0] op_vaddr;
  logic [4:0] op_size_code, op_bank0, mem_bank0, mem_size_code;
  logic [8:0] op_reg_no, mem_reg_no;
  logic [54:0] tlb_vpn, tlb_vpn_next;
  logic tlb_hit, csr_en, mem_valid, mem_stall, mem_store, page_fault, tlb_miss;
  agu_pkg::tlb_entry_t tlb_data, tlb_data_next;
  logic [14:0] csr_no;
  logic [63:0] csr_data;
  logic [35:0] mem_addr_even, mem_addr_odd;
  logic [31:0] mem_banks;
  logic [3:0] mem_fault_code;

  logic [54:0] slot_key [slots];
  agu_pkg::tlb_entry_t slot_entry [slots];
  logic slot_used [slots];
  logic cur_found, next_found;
  logic [23:0] exp_proc;
  logic [8:0] got_reg [8];
  int errors, checks, seed, got_count;

  agu_top u_agu_top (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // TLB model answering in the same cycle
  always_comb begin
    cur_found = 1'b0;
    next_found = 1'b0;
    tlb_data = '0;
    tlb_data_next = '0;
    for (int i = 0; i < slots; i++) begin
      if (slot_used[i] && slot_key[i] == tlb_vpn) begin
        cur_found = 1'b1;
        tlb_data = slot_entry[i];
      end
      if (slot_used[i] && slot_key[i] == tlb_vpn_next) begin
        next_found = 1'b1;
        tlb_data_next = slot_entry[i];
      end
    end
    tlb_hit = cur_found & next_found;  // both pages must be resident
  end

  function automatic agu_pkg::tlb_entry_t table_entry(input logic [54:0] key);
    table_entry = '0;
    for (int i = 0; i < slots; i++)
      if (slot_used[i] && slot_key[i] == key)
        table_entry = slot_entry[i];
  endfunction

  function automatic int banks_touched(input logic [4:0] code, input logic [1:0] low);
    case (code)
      5'd16: return 1;
      5'd17: return (low == 2'd3) ? 2 : 1;
      5'd18, 5'd4, 5'd5, 5'd6: return (low != 2'd0) ? 2 : 1;
      5'd3: return (low == 2'd3) ? 4 : 3;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return (low != 2'd0) ? 5 : 4;
      5'd15: return 5;
      default: return (low != 2'd0) ? 3 : 2;  // 8-byte class
    endcase
  endfunction

  function automatic logic [31:0] bank_mask(input logic [4:0] bank0, input int n);
    bank_mask = '0;
    for (int k = 0; k < n; k++)
      bank_mask[(bank0 + k) % 32] = 1'b1;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    errors += u_agu_top.u_ctrl.u_asserts.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    finish_run();
  endtask

  task automatic to_drive_point();
    @(posedge clk);
    #2;
  endtask

  task automatic map_page(input int slot, input logic [30:0] vpn, input logic [30:0] ppn,
                          input logic sys, input logic present);
    slot_key[slot] = {exp_proc, vpn};
    slot_entry[slot] = '{ppn: ppn, sys: sys, present: present};
    slot_used[slot] = 1'b1;
  endtask

  task automatic issue(input logic [43:0] vaddr, input logic [4:0] code, input logic [4:0] bank0,
                       input logic split, input logic [8:0] reg_no, input logic kernel);
    int waited;
    waited = 0;
    op_vaddr = vaddr;
    op_size_code = code;
    op_bank0 = bank0;
    op_split = split;
    op_reg_no = reg_no;
    op_store = reg_no[0];  // vary the store flag
    op_kernel = kernel;
    op_valid = 1'b1;
    @(negedge clk);
    while (!op_ready) begin
      waited++;
      if (waited > wait_limit)
        abort_on_timeout("op_ready");
      @(negedge clk);
    end
    to_drive_point();
    op_valid = 1'b0;
  endtask

  task automatic wait_mem_valid();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!mem_valid) begin
      waited++;
      if (waited > wait_limit)
        abort_on_timeout("mem_valid");
      @(negedge clk);
    end
  endtask

  // expected result from the last issued op fields and the TLB table
  task automatic expect_op();
    agu_pkg::tlb_entry_t cur, nxt;
    logic [36:0] row_cur, row_next;
    logic crossing;
    logic [3:0] faults;
    wait_mem_valid();
    cur = table_entry({exp_proc, op_vaddr[43:13]});
    nxt = table_entry({exp_proc, op_vaddr[43:13] + 31'd1});
    crossing = (op_vaddr[12:7] == 6'h3f);  // last row of the page
    row_cur = {cur.ppn, op_vaddr[12:7]};
    row_next = crossing ? {nxt.ppn, 6'd0} : row_cur + 37'd1;
    faults = {op_split & crossing & nxt.sys & ~op_kernel, op_split & crossing & ~nxt.present,
              cur.sys & ~op_kernel, ~cur.present};
    check_eq("mem_addr_even", mem_addr_even, op_vaddr[7] ? row_next[36:1] : row_cur[36:1]);
    check_eq("mem_addr_odd", mem_addr_odd, op_vaddr[7] ? row_cur[36:1] : row_next[36:1]);
    check_eq("mem_banks", mem_banks,
             bank_mask(op_bank0, banks_touched(op_size_code, op_vaddr[1:0])));
    check_eq("mem_fault_code", mem_fault_code, faults);
    check_eq("page_fault", page_fault, |faults);
    check_eq("mem_reg_no", mem_reg_no, op_reg_no);
    check_eq("mem_store", mem_store, op_store);
    check_eq("mem_bank0", mem_bank0, op_bank0);
    check_eq("mem_size_code", mem_size_code, op_size_code);
    to_drive_point();
  endtask

  task automatic run_op(input logic [43:0] vaddr, input logic [4:0] code, input logic [4:0] bank0,
                        input logic split, input logic [8:0] reg_no, input logic kernel);
    issue(vaddr, code, bank0, split, reg_no, kernel);
    expect_op();
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_eq("mem_valid", mem_valid, 1'b0);
    end
    to_drive_point();
  endtask

  task automatic csr_write(input logic [14:0] no, input logic [63:0] data);
    csr_en = 1'b1;
    csr_no = no;
    csr_data = data;
    to_drive_point();
    csr_en = 1'b0;
    if (no == agu_pkg::csr_proc_no)
      exp_proc = data[63:40];
  endtask

  task automatic sweep_bank_masks();
    logic [4:0] codes [11] = '{16, 17, 18, 19, 3, 0, 4, 8, 12, 15, 7};
    logic [43:0] va;
    map_page(0, 31'h100, 31'h4a10, 1'b0, 1'b1);
    map_page(1, 31'h101, 31'h0777, 1'b0, 1'b1);
    foreach (codes[c])
      for (int low = 0; low < 4; low++) begin
        va = {31'h100, 13'($random(seed))};
        va[1:0] = low[1:0];
        // bank0 of 30 with five banks wraps past 31
        run_op(va, codes[c], (c == 9) ? 5'd30 : 5'($random(seed)), 1'b0, 9'(c), 1'b1);
      end
  endtask

  task automatic row_address_ops();
    map_page(2, 31'h200, 31'h1234567, 1'b0, 1'b1);
    map_page(3, 31'h201, 31'h7654321, 1'b0, 1'b1);
    run_op({31'h200, 13'h0410}, 5'd18, 5'd4, 1'b0, 9'h20, 1'b1);
    run_op({31'h200, 13'h0a9c}, 5'd18, 5'd7, 1'b0, 9'h21, 1'b1);
    run_op({31'h200, 13'h1f00}, 5'd18, 5'd0, 1'b0, 9'h22, 1'b1);
    run_op({31'h200, 13'h1f84}, 5'd19, 5'd1, 1'b1, 9'h23, 1'b1);  // last row
    check_eq("mem_addr_even[35:5]", mem_addr_even[35:5], 31'h7654321);
  endtask

  task automatic fault_code_ops();
    map_page(4, 31'h300, 31'h30, 1'b1, 1'b1);
    map_page(5, 31'h301, 31'h31, 1'b0, 1'b1);
    map_page(6, 31'h310, 31'h40, 1'b0, 1'b0);
    map_page(7, 31'h311, 31'h41, 1'b0, 1'b1);
    map_page(8, 31'h320, 31'h50, 1'b0, 1'b1);
    map_page(9, 31'h321, 31'h51, 1'b1, 1'b0);
    run_op({31'h300, 13'h0040}, 5'd18, 5'd0, 1'b0, 9'h30, 1'b0);
    check_eq("mem_fault_code", mem_fault_code, 4'h2);
    run_op({31'h300, 13'h0040}, 5'd18, 5'd0, 1'b0, 9'h31, 1'b1);
    check_eq("mem_fault_code", mem_fault_code, 4'h0);
    run_op({31'h310, 13'h0100}, 5'd18, 5'd0, 1'b0, 9'h32, 1'b1);
    check_eq("mem_fault_code", mem_fault_code, 4'h1);
    run_op({31'h320, 13'h1ffc}, 5'd19, 5'd31, 1'b1, 9'h33, 1'b0);
    check_eq("mem_fault_code", mem_fault_code, 4'hc);
  endtask

  task automatic latency_and_miss();
    int edges;
    edges = 1;  // the accepting edge
    issue({31'h100, 13'h0200}, 5'd18, 5'd0, 1'b0, 9'h40, 1'b1);
    @(negedge clk);
    while (!mem_valid) begin
      if (edges > wait_limit)
        abort_on_timeout("mem_valid after a TLB hit");
      @(negedge clk);
      edges++;
    end
    check_eq("mem_valid latency", edges, 2);
    to_drive_point();
    issue({31'h400, 13'h0080}, 5'd18, 5'd0, 1'b0, 9'h41, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_eq("tlb_miss", tlb_miss, 1'b1);
      check_eq("op_ready", op_ready, 1'b0);
      check_eq("mem_valid", mem_valid, 1'b0);
    end
    to_drive_point();
    map_page(10, 31'h400, 31'h2222, 1'b0, 1'b1);
    map_page(11, 31'h401, 31'h2223, 1'b0, 1'b1);
    expect_op();
  endtask

  task automatic collect_stalled(input int want);
    int cycle;
    logic held;
    logic [8:0] held_reg;
    logic [35:0] held_even;
    cycle = 0;
    held = 1'b0;
    while (got_count < want) begin
      if (cycle > wait_limit)
        abort_on_timeout("the stalled burst to drain");
      mem_stall = (cycle % 3) != 2;  // mostly stalled
      @(negedge clk);
      if (held) begin
        check_eq("mem_valid", mem_valid, 1'b1);
        check_eq("mem_reg_no", mem_reg_no, held_reg);
        check_eq("mem_addr_even", mem_addr_even, held_even);
      end
      held = mem_valid & mem_stall;
      held_reg = mem_reg_no;
      held_even = mem_addr_even;
      if (mem_valid && !mem_stall) begin
        got_reg[got_count] = mem_reg_no;
        got_count++;
      end
      to_drive_point();
      cycle++;
    end
    mem_stall = 1'b0;
  endtask

  task automatic burst_and_flush();
    got_count = 0;
    fork
      for (int i = 0; i < 4; i++)
        issue({31'h100, 13'(i * 256)}, 5'd19, 5'(i), 1'b0, 9'h50 + 9'(i), 1'b1);
      collect_stalled(4);
    join
    for (int i = 0; i < 4; i++)
      check_eq("mem_reg_no", got_reg[i], 9'h50 + 9'(i));
    check_idle(4);
    issue({31'h100, 13'h0300}, 5'd18, 5'd2, 1'b0, 9'h60, 1'b1);
    except = 1'b1;  // op still in stage 1
    @(negedge clk);
    check_eq("op_ready", op_ready, 1'b0);
    to_drive_point();
    except = 1'b0;
    check_idle(5);
    mem_stall = 1'b1;
    issue({31'h100, 13'h0340}, 5'd18, 5'd3, 1'b0, 9'h61, 1'b1);
    wait_mem_valid();
    to_drive_point();
    except = 1'b1;  // op held in stage 2
    to_drive_point();
    except = 1'b0;
    mem_stall = 1'b0;
    check_idle(5);
  endtask

  task automatic proc_id_write();
    csr_write(agu_pkg::csr_proc_no, {24'h5a3c96, 40'h12345});
    csr_write(15'h0c05, {24'h111111, 40'h0});  // other CSR is ignored
    map_page(12, 31'h100, 31'h0abc, 1'b0, 1'b1);
    map_page(13, 31'h101, 31'h0abd, 1'b0, 1'b1);
    issue({31'h100, 13'h0008}, 5'd17, 5'd9, 1'b0, 9'h70, 1'b1);
    @(negedge clk);
    check_eq("tlb_vpn", tlb_vpn, {24'h5a3c96, 31'h100});
    check_eq("tlb_vpn_next", tlb_vpn_next, {24'h5a3c96, 31'h101});
    expect_op();
  endtask

  initial begin
    seed = 32'haa95;
    errors = 0;
    checks = 0;
    got_count = 0;
    exp_proc = '0;
    rst = 1'b1;
    except = 1'b0;
    op_valid = 1'b0;
    op_vaddr = '0;
    op_size_code = '0;
    op_bank0 = '0;
    op_store = 1'b0;
    op_split = 1'b0;
    op_reg_no = '0;
    op_kernel = 1'b0;
    mem_stall = 1'b0;
    csr_en = 1'b0;
    csr_no = '0;
    csr_data = '0;
    for (int i = 0; i < slots; i++)
      slot_used[i] = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    check_eq("op_ready", op_ready, 1'b0);  // one idle cycle out of reset
    check_eq("mem_valid", mem_valid, 1'b0);
    check_eq("tlb_miss", tlb_miss, 1'b0);
    check_eq("page_fault", page_fault, 1'b0);
    to_drive_point();
    sweep_bank_masks();
    row_address_ops();
    fault_code_ops();
    latency_and_miss();
    burst_and_flush();
    proc_id_write();
    finish_run();
  end

endmodule

// File: all.f
src/agu_pkg.sv
src/stage_reg.sv
src/agu_ctrl.sv
src/bank_mask_gen.sv
src/paddr_compose.sv
src/fault_check.sv
src/agu_csr.sv
src/agu_top.sv
testbench/agu_asserts.sv
testbench/tb_agu.sv

// File: Bender.yml
package:
  name: agu

sources:
  # RTL, package first
  - files:
      - src/agu_pkg.sv
      - src/stage_reg.sv
      - src/agu_ctrl.sv
      - src/bank_mask_gen.sv
      - src/paddr_compose.sv
      - src/fault_check.sv
      - src/agu_csr.sv
      - src/agu_top.sv
  # testbench, top module tb_agu
  - target: test
    files:
      - testbench/agu_asserts.sv
      - testbench/tb_agu.sv
